// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int IMEM_DEPTH = 256;   // instruction words
  localparam int DMEM_DEPTH = 16;    // data words
  localparam int NUM_REGS   = 16;    // x0..x15

  // instruction layout: imm | rs2 | rs1 | rd | opt | opcode
  localparam int FIELD_W = 4;        // width of every small field
  localparam int IMM_W   = 12;
  localparam int OPC_LSB = 0;
  localparam int OPT_LSB = 4;
  localparam int RD_LSB  = 8;
  localparam int RS1_LSB = 12;
  localparam int RS2_LSB = 16;
  localparam int IMM_LSB = 20;

  typedef logic [XLEN-1:0]               word_t;     // register, memory and instruction word
  typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;  // register index
  typedef logic [IMM_W-1:0]              imm_t;      // zero-extended on use
  typedef logic [$clog2(IMEM_DEPTH)-1:0] pc_t;       // word address into rom
  typedef logic [$clog2(DMEM_DEPTH)-1:0] daddr_t;    // word address into mem_file

  typedef enum logic [FIELD_W-1:0] {
    ADDI = 4'd0,
    ADD  = 4'd1,
    JALR = 4'd2,
    JEQ  = 4'd3,
    LW   = 4'd4,
    SW   = 4'd5,
    HALT = 4'd10   // remaining codes fall through as no-op
  } opcode_t;

  typedef enum logic [1:0] {
    IDLE,     // waiting for a run edge
    RUN,      // one instruction per clock
    HALTED    // stopped until run drops
  } core_state_t;

endpackage

// ==== verilog/dmem_if.sv ====
`timescale 1ns/1ps

interface dmem_if import cpu_pkg::*; ();

  logic   we;      // write strobe, lands on the clock edge
  daddr_t addr;    // word address
  word_t  wdata;   // store data
  word_t  rdata;   // addressed word, same cycle

  modport master (
    output we, addr, wdata,
    input  rdata
  );

  modport slave (
    input  we, addr, wdata,
    output rdata
  );

endinterface

// ==== verilog/rom.sv ====
`timescale 1ns/1ps

module rom import cpu_pkg::*; (
  input  logic  clk,
  input  logic  prog_we,      // host write strobe
  input  pc_t   prog_addr,
  input  word_t prog_data,
  input  pc_t   fetch_addr,   // from core pc
  output word_t fetch_data    // instruction back to core
);

  word_t mem [IMEM_DEPTH];    // not cleared, host loads it

  // host side, one word per clock while prog_we is high
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // fetch is combinational so decode sees the word in the same cycle
  assign fetch_data = mem[fetch_addr];

endmodule

// ==== verilog/gr_file.sv ====
`timescale 1ns/1ps

module gr_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t ra1,        // rs1 read port
  input  reg_idx_t ra2,        // rs2 read port
  output word_t    rd1,
  output word_t    rd2,
  input  logic     we,
  input  reg_idx_t wa,
  input  word_t    wd,
  input  reg_idx_t dbg_addr,   // host peek
  output word_t    dbg_data
);

  word_t x [1:NUM_REGS-1];     // x0 has no storage

  function automatic word_t read_reg(input reg_idx_t idx);
    word_t val;
    val = '0;                  // x0 reads zero
    if (idx != '0) begin
      val = x[idx];
    end
    return val;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        x[i] <= '0;
      end
    end else if (we && (wa != '0)) begin   // writes to x0 dropped
      x[wa] <= wd;
    end
  end

  assign rd1      = read_reg(ra1);
  assign rd2      = read_reg(ra2);
  assign dbg_data = read_reg(dbg_addr);    // registered value, no write bypass

endmodule

// ==== verilog/mem_file.sv ====
`timescale 1ns/1ps

module mem_file import cpu_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  dmem_if.slave  bus          // requests from cpu
);

  word_t mem [DMEM_DEPTH];

  // whole array comes up zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (bus.we) begin
      mem[bus.addr] <= bus.wdata;   // sw lands on this edge
    end
  end

  // lw gets the word in the same cycle it is addressed
  assign bus.rdata = mem[bus.addr];

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,          // host start, level
  output pc_t      fetch_addr,
  input  word_t    fetch_data,
  dmem_if.master   dmem,
  input  reg_idx_t dbg_addr,
  output word_t    dbg_data,
  output logic     halted,
  output logic     store_valid,  // one pulse per sw
  output daddr_t   store_addr,
  output word_t    store_data
);

  core_state_t          state;
  pc_t                  pc;
  logic                 run_q;        // run delayed, for edge detect
  opcode_t              opcode;
  logic [FIELD_W-1:0]   opt;
  reg_idx_t             rd_idx;
  reg_idx_t             rs1_idx;
  reg_idx_t             rs2_idx;
  imm_t                 imm;
  word_t                imm_ext;
  word_t                rs1_val;
  word_t                rs2_val;
  word_t                ea;           // rs1 + imm, shared by addi/lw/sw
  word_t                rf_wd;
  logic                 rf_we;
  logic                 exec;
  logic                 take_branch;
  pc_t                  pc_inc;
  pc_t                  pc_next;

  // field split of the fetched word
  assign opcode  = opcode_t'(fetch_data[OPC_LSB +: FIELD_W]);
  assign opt     = fetch_data[OPT_LSB +: FIELD_W];
  assign rd_idx  = fetch_data[RD_LSB  +: FIELD_W];
  assign rs1_idx = fetch_data[RS1_LSB +: FIELD_W];
  assign rs2_idx = fetch_data[RS2_LSB +: FIELD_W];
  assign imm     = fetch_data[IMM_LSB +: IMM_W];
  assign imm_ext = word_t'(imm);      // zero-extend

  assign exec        = (state == RUN);
  assign pc_inc      = pc + pc_t'(1);
  assign ea          = rs1_val + imm_ext;
  // opt bit 0 picks nonzero test, else zero test
  assign take_branch = opt[0] ? (rs2_val != '0) : (rs2_val == '0);

  always_comb begin
    rf_we   = 1'b0;
    rf_wd   = ea;
    pc_next = pc_inc;                 // default fall-through
    case (opcode)
      ADDI: rf_we = 1'b1;
      ADD: begin
        rf_we = 1'b1;
        rf_wd = rs1_val + rs2_val;
      end
      JALR: begin
        rf_we   = 1'b1;
        rf_wd   = word_t'(pc_inc);    // link, rs1 already read this cycle
        pc_next = pc_t'(rs1_val);
      end
      JEQ: begin
        if (take_branch) begin
          pc_next = pc_t'(rs1_val);
        end
      end
      LW: begin
        rf_we = 1'b1;
        rf_wd = dmem.rdata;
      end
      default: ;                      // sw, halt and unknown codes write nothing
    endcase
  end

  gr_file gr_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .ra1      (rs1_idx),
    .ra2      (rs2_idx),
    .rd1      (rs1_val),
    .rd2      (rs2_val),
    .we       (exec && rf_we),        // only retire while running
    .wa       (rd_idx),
    .wd       (rf_wd),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  assign dmem.we    = exec && (opcode == SW);
  assign dmem.addr  = daddr_t'(ea);   // low bits of the address
  assign dmem.wdata = rs2_val;

  assign fetch_addr = pc;
  assign halted     = (state == HALTED);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      pc          <= '0;
      run_q       <= 1'b0;
      store_valid <= 1'b0;
    end else begin
      run_q       <= run;
      store_valid <= dmem.we;         // trace shows up the cycle after the store
      case (state)
        IDLE: begin
          if (run && !run_q) begin    // rising edge only
            state <= RUN;
            pc    <= '0;
          end
        end
        RUN: begin
          if (opcode == HALT) state <= HALTED;   // pc parks on the halt
          else                pc    <= pc_next;
        end
        HALTED: begin
          if (!run) begin
            state <= IDLE;
            pc    <= '0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // trace payload, qualified by store_valid
  always_ff @(posedge clk) begin
    if (dmem.we) begin
      store_addr <= dmem.addr;
      store_data <= dmem.wdata;
    end
  end

endmodule

// ==== verilog/mother_board.sv ====
`timescale 1ns/1ps

module mother_board import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,          // start program at pc 0
  input  logic     prog_we,      // host loads rom while run is low
  input  pc_t      prog_addr,
  input  word_t    prog_data,
  input  reg_idx_t dbg_addr,
  output word_t    dbg_data,     // x[dbg_addr], combinational
  output logic     halted,
  output logic     store_valid,
  output daddr_t   store_addr,
  output word_t    store_data
);

  pc_t   fetch_addr;             // cpu pc into rom
  word_t fetch_data;             // instruction back

  dmem_if dmem ();               // cpu to data memory

  rom rom (
    .clk        (clk),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data)
  );

  cpu cpu (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .dmem        (dmem.master),
    .dbg_addr    (dbg_addr),
    .dbg_data    (dbg_data),
    .halted      (halted),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  mem_file mem_file (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (dmem.slave)
  );

endmodule

// ==== test/tb_mother_board.sv ====
`timescale 1ns/1ps

module tb_mother_board import cpu_pkg::*; ();

  localparam int HALT_TIMEOUT = 2000;   // cycles allowed per program
  localparam int MAX_STORES   = 64;

  logic     clk;
  logic     rst_n;
  logic     run;
  logic     prog_we;
  pc_t      prog_addr;
  word_t    prog_data;
  reg_idx_t dbg_addr;
  word_t    dbg_data;
  logic     halted;
  logic     store_valid;
  daddr_t   store_addr;
  word_t    store_data;

  word_t    prog [IMEM_DEPTH];          // mirror of rom contents
  word_t    exp_regs [NUM_REGS];
  daddr_t   exp_st_addr [MAX_STORES];
  word_t    exp_st_data [MAX_STORES];
  int       exp_st_cnt;
  daddr_t   obs_addr [$];               // store trace as seen on the ports
  word_t    obs_data [$];
  int       n_checks;
  int       n_errors;
  word_t    val;
  int       len;

  mother_board DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .dbg_addr    (dbg_addr),
    .dbg_data    (dbg_data),
    .halted      (halted),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  always #20 clk = ~clk;                // 40 ns period

  task automatic check(input string name, input word_t exp_val, input word_t act_val);
    n_checks++;
    if (act_val !== exp_val) begin
      n_errors++;
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  // word layout imm | rs2 | rs1 | rd | opt | opcode
  function automatic word_t encode(input logic [3:0] op, input logic [3:0] opt,
                                   input logic [3:0] rd, input logic [3:0] rs1,
                                   input logic [3:0] rs2, input logic [11:0] imm);
    return {imm, rs2, rs1, rd, opt, op};
  endfunction

  // instruction-level interpreter that fills exp_regs and the expected store list
  function automatic void run_model(input int max_steps);
    pc_t        pc;
    word_t      r [NUM_REGS];
    word_t      m [DMEM_DEPTH];
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      ea;
    logic [3:0] rd;
    logic       done;
    pc = '0;
    done = 1'b0;
    exp_st_cnt = 0;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;                        // r[0] is never written
      m[i] = '0;
    end
    for (int s = 0; s < max_steps && !done; s++) begin
      ins = prog[pc];
      rd  = ins[11:8];
      a   = r[ins[15:12]];
      b   = r[ins[19:16]];
      ea  = a + {20'd0, ins[31:20]};    // zero-extended imm
      pc  = pc + 8'd1;                  // now holds the link value
      case (ins[3:0])
        4'd0: if (rd != 0) r[rd] = ea;
        4'd1: if (rd != 0) r[rd] = a + b;
        4'd2: begin
          if (rd != 0) r[rd] = {24'd0, pc};
          pc = a[7:0];
        end
        4'd3: if (ins[4] ? (b != 0) : (b == 0)) pc = a[7:0];
        4'd4: if (rd != 0) r[rd] = m[ea[3:0]];
        4'd5: begin
          m[ea[3:0]] = b;
          if (exp_st_cnt < MAX_STORES) begin
            exp_st_addr[exp_st_cnt] = ea[3:0];
            exp_st_data[exp_st_cnt] = b;
          end
          exp_st_cnt++;
        end
        4'd10: done = 1'b1;
        default: ;                      // no-op
      endcase
    end
    for (int i = 0; i < 16; i++) exp_regs[i] = r[i];
  endfunction

  // compares each store pulse against the model as it arrives
  always @(negedge clk) begin
    if (rst_n && store_valid) begin
      if (obs_addr.size() < exp_st_cnt && obs_addr.size() < MAX_STORES) begin
        check("store_addr", word_t'(exp_st_addr[obs_addr.size()]), word_t'(store_addr));
        check("store_data", exp_st_data[obs_addr.size()], store_data);
      end else begin
        n_errors++;
        $display("unexpected store at %0t to address %0d", $time, store_addr);
      end
      obs_addr.push_back(store_addr);
      obs_data.push_back(store_data);
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #2 rst_n = 1'b0;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
  endtask

  task automatic load_program(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #2 prog_we = 1'b1;
      prog_addr = pc_t'(i);
      prog_data = prog[i];
    end
    @(posedge clk);
    #2 prog_we = 1'b0;
  endtask

  task automatic read_reg(input int idx, output word_t data);
    @(posedge clk);
    #2 dbg_addr = reg_idx_t'(idx);
    @(negedge clk);                     // debug port is combinational
    data = dbg_data;
  endtask

  task automatic start_and_wait();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2 run = 1'b1;
    @(negedge clk);
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      n_errors++;
      $display("timeout at %0t: halted did not rise within %0d cycles", $time, HALT_TIMEOUT);
    end
  endtask

  // reset, load, predict, run, then compare registers and store count
  task automatic run_scenario(input int n);
    word_t data;
    apply_reset();
    load_program(n);
    run_model(1000);
    obs_addr.delete();
    obs_data.delete();
    start_and_wait();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_reg(i, data);
      check($sformatf("x%0d", i), exp_regs[i], data);
    end
    check("store count", word_t'(exp_st_cnt), word_t'(obs_addr.size()));
    @(posedge clk);
    #2 run = 1'b0;
  endtask

  task automatic jeq_case(input logic [3:0] opt, input logic [11:0] v);
    word_t data;
    prog[0] = encode(ADDI, 0, 1, 0, 0, 4);   // x1 = jump target
    prog[1] = encode(ADDI, 0, 2, 0, 0, v);
    prog[2] = encode(JEQ, opt, 0, 1, 2, 0);
    prog[3] = encode(HALT, 0, 0, 0, 0, 0);
    prog[4] = encode(ADDI, 0, 5, 0, 0, 3);
    prog[5] = encode(HALT, 0, 0, 0, 0, 0);
    run_scenario(6);
    read_reg(5, data);
    check($sformatf("x5 jeq opt %0d v %0d", opt, v),
          ((opt == 0) == (v == 0)) ? 32'd3 : 32'd0, data);
  endtask

  initial begin
    clk = 0;
    rst_n = 0;
    run = 0;
    prog_we = 0;
    prog_addr = '0;
    prog_data = '0;
    dbg_addr = '0;
    n_checks = 0;
    n_errors = 0;
    exp_st_cnt = 0;
    val = $urandom(32'h7ae318bb);       // seed once

    prog[0] = encode(ADDI, 0, 1, 0, 0, 1);   // arithmetic chain
    prog[1] = encode(ADDI, 0, 2, 1, 0, 2);
    prog[2] = encode(ADDI, 0, 3, 2, 0, 1);
    prog[3] = encode(ADD, 0, 4, 3, 2, 0);
    prog[4] = encode(HALT, 0, 0, 0, 0, 0);
    run_scenario(5);
    read_reg(1, val);
    check("x1", 1, val);
    read_reg(3, val);
    check("x3", 4, val);
    read_reg(4, val);
    check("x4", 7, val);

    prog[0] = encode(ADDI, 0, 1, 0, 0, 3);   // store then load back
    prog[1] = encode(ADDI, 0, 2, 0, 0, 7);
    prog[2] = encode(SW, 0, 0, 1, 2, 0);
    prog[3] = encode(LW, 0, 4, 0, 0, 3);
    prog[4] = encode(HALT, 0, 0, 0, 0, 0);
    run_scenario(5);
    if (obs_addr.size() > 0) begin
      check("trace addr", 3, word_t'(obs_addr[0]));
      check("trace data", 7, obs_data[0]);
    end
    read_reg(4, val);
    check("x4 after lw", 7, val);

    prog[0] = encode(ADDI, 0, 1, 0, 0, 4);   // jalr over two halts
    prog[1] = encode(JALR, 0, 2, 1, 0, 0);
    prog[2] = encode(HALT, 0, 0, 0, 0, 0);
    prog[3] = encode(HALT, 0, 0, 0, 0, 0);
    prog[4] = encode(ADDI, 0, 5, 0, 0, 3);
    prog[5] = encode(HALT, 0, 0, 0, 0, 0);
    run_scenario(6);
    read_reg(2, val);
    check("x2 link", 2, val);
    read_reg(5, val);
    check("x5 after jalr", 3, val);

    jeq_case(0, 0);
    jeq_case(0, 1);
    jeq_case(1, 1);
    jeq_case(1, 0);

    prog[0] = encode(ADDI, 0, 0, 0, 0, 9);   // write to x0 is dropped
    prog[1] = encode(ADDI, 0, 1, 0, 0, 5);
    prog[2] = encode(HALT, 0, 0, 0, 0, 0);
    run_scenario(3);
    read_reg(0, val);
    check("x0", 0, val);
    start_and_wait();                        // halted again with run held high
    @(posedge clk);
    #2 rst_n = 1'b0;
    #1 check("halted in reset", 0, word_t'(halted));
    apply_reset();
    @(negedge clk);
    check("store_valid after reset", 0, word_t'(store_valid));
    for (int i = 0; i < NUM_REGS; i++) begin
      read_reg(i, val);
      check($sformatf("x%0d after reset", i), 0, val);
    end

    for (int p = 0; p < 20; p++) begin       // random addi/add/sw/lw programs
      len = 4 + ($urandom % 13);
      for (int i = 0; i < len; i++) begin
        case ($urandom % 4)
          0: val = ADDI;
          1: val = ADD;
          2: val = SW;
          default: val = LW;
        endcase
        prog[i] = encode(val[3:0], $urandom, $urandom, $urandom, $urandom, $urandom);
      end
      prog[len] = encode(HALT, 0, 0, 0, 0, 0);
      run_scenario(len + 1);
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/cpu_pkg.sv
verilog/dmem_if.sv
verilog/rom.sv
verilog/gr_file.sv
verilog/mem_file.sv
verilog/cpu.sv
verilog/mother_board.sv
test/tb_mother_board.sv

// ==== Bender.yml ====
package:
  name: mother_board

sources:
  - verilog/cpu_pkg.sv
  - verilog/dmem_if.sv
  - verilog/rom.sv
  - verilog/gr_file.sv
  - verilog/mem_file.sv
  - verilog/cpu.sv
  - verilog/mother_board.sv
  - target: simulation
    files:
      - test/tb_mother_board.sv
